/* build.f */
common/eth_fifo_pkg.sv
source/rx_frame_checker.sv
frame_fifo/frame_fifo.sv
source/rx_output_stage.sv
source/eth_rx_fifo_top.sv
testbench/tb_clock_gen.sv
testbench/tb_eth_rx_fifo.sv

/* common/eth_fifo_pkg.sv */
// Beat, write, length and status types with the receive FIFO default constants
package eth_fifo_pkg;

    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    localparam int DEFAULT_FIFO_DEPTH  = 512; // In beats
    localparam int DEFAULT_MAX_PKT_LEN = 1518;

    typedef logic [15:0] pkt_len_t;

    // One MAC-side beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              bad;
    } rx_beat_t;

    // Checker to FIFO write strobe
    typedef struct packed {
        logic     wr;
        rx_beat_t beat;
        logic     drop; // Only meaningful on the last beat
    } fifo_wr_t;

    // One-cycle status pulses
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

endpackage

/* frame_fifo/frame_fifo.sv */
// Frame-mode FIFO with speculative writes, commit or rollback, and status pulses
`timescale 1ns/100ps

module frame_fifo
    import eth_fifo_pkg::*;
#(
    parameter int DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  fifo_wr_t     fifo_wr,
    input  logic         rd_en,
    output rx_beat_t     rd_beat,
    output logic         rd_avail,
    output fifo_status_t status
);

    localparam int AW = $clog2(DEPTH);

    typedef logic [AW:0] ptr_t; // Extra bit tells full from empty

    rx_beat_t ram [DEPTH];

    ptr_t wr_ptr;     // Speculative, runs ahead inside a frame
    ptr_t commit_ptr; // End of the last good frame
    ptr_t rd_ptr;
    logic frame_full; // Frame lost a beat to a full FIFO

    logic full;
    logic wr_ok;
    ptr_t wr_ptr_inc;

    fifo_status_t status_q;

    always_comb begin
        full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
        wr_ok      = fifo_wr.wr && !full && !frame_full;
        wr_ptr_inc = wr_ptr + 1'b1;
    end

    assign rd_avail = rd_ptr != commit_ptr;

    // RAM write and registered read
    always_ff @(posedge logic_clk) begin
        if (wr_ok) begin
            ram[wr_ptr[AW-1:0]] <= fifo_wr.beat;
        end
        if (rd_en) begin
            rd_beat <= ram[rd_ptr[AW-1:0]];
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            frame_full <= 1'b0;
            status_q   <= '0;
        end else begin
            status_q <= '0;

            if (fifo_wr.wr) begin
                if (fifo_wr.beat.last) begin
                    frame_full <= 1'b0;
                    if (frame_full || full) begin
                        wr_ptr            <= commit_ptr; // Rewind the partial frame
                        status_q.overflow <= 1'b1;
                    end else if (fifo_wr.drop) begin
                        wr_ptr             <= commit_ptr;
                        status_q.bad_frame <= 1'b1;
                    end else begin
                        wr_ptr              <= wr_ptr_inc;
                        commit_ptr          <= wr_ptr_inc;
                        status_q.good_frame <= 1'b1;
                    end
                end else if (frame_full || full) begin
                    frame_full <= 1'b1; // Held until the last beat
                end else begin
                    wr_ptr <= wr_ptr_inc;
                end
            end

            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign status = status_q;

    // Consumer only pops committed beats
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        rd_en |-> rd_avail);

endmodule

/* source/eth_rx_fifo_top.sv */
// Receive frame FIFO top level joining the checker, the frame FIFO and the output stage
`timescale 1ns/100ps

module eth_rx_fifo_top
    import eth_fifo_pkg::*;
#(
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  rx_beat_t     rx_in,
    input  logic         rx_in_valid,
    input  pkt_len_t     cfg_max_pkt_len,
    output rx_beat_t     rx_out,
    output logic         rx_out_valid,
    input  logic         rx_out_ready,
    output fifo_status_t status
);

    fifo_wr_t fifo_wr;
    rx_beat_t rd_beat;
    logic     rd_avail;
    logic     rd_en;

    rx_frame_checker i_checker (
        .logic_clk       (logic_clk),
        .logic_rst       (logic_rst),
        .rx_in           (rx_in),
        .rx_in_valid     (rx_in_valid),
        .cfg_max_pkt_len (cfg_max_pkt_len),
        .fifo_wr         (fifo_wr)
    );

    frame_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .fifo_wr   (fifo_wr),
        .rd_en     (rd_en),
        .rd_beat   (rd_beat),
        .rd_avail  (rd_avail),
        .status    (status)
    );

    rx_output_stage i_output (
        .logic_clk    (logic_clk),
        .logic_rst    (logic_rst),
        .rd_beat      (rd_beat),
        .rd_avail     (rd_avail),
        .rd_en        (rd_en),
        .rx_out       (rx_out),
        .rx_out_valid (rx_out_valid),
        .rx_out_ready (rx_out_ready)
    );

endmodule

/* source/rx_frame_checker.sv */
// Receive frame checker with byte counting, oversize and bad frame detection
`timescale 1ns/100ps

module rx_frame_checker
    import eth_fifo_pkg::*;
(
    input  logic     logic_clk,
    input  logic     logic_rst,
    input  rx_beat_t rx_in,
    input  logic     rx_in_valid,
    input  pkt_len_t cfg_max_pkt_len,
    output fifo_wr_t fifo_wr
);

    localparam int CNT_W = $clog2(KEEP_W + 1);

    pkt_len_t   byte_cnt;   // Bytes seen so far in this frame
    logic       bad_seen;
    logic [CNT_W-1:0] beat_bytes;
    logic [16:0] cnt_sum;
    pkt_len_t   cnt_next;
    logic       oversize;
    logic       bad_next;

    logic       wr_q;
    rx_beat_t   beat_q;
    logic       drop_q;

    function automatic logic [CNT_W-1:0] keep_bytes(input logic [KEEP_W-1:0] keep);
        logic [CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            n = n + CNT_W'(keep[i]);
        end
        return n;
    endfunction

    always_comb begin
        beat_bytes = keep_bytes(rx_in.keep);
        cnt_sum    = {1'b0, byte_cnt} + 17'(beat_bytes);
        cnt_next   = cnt_sum[16] ? '1 : cnt_sum[15:0]; // Saturate on jumbo runaway
        oversize   = cnt_next > cfg_max_pkt_len;
        bad_next   = bad_seen | rx_in.bad;
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            byte_cnt <= '0;
            bad_seen <= 1'b0;
            wr_q     <= 1'b0;
        end else begin
            wr_q <= rx_in_valid;
            if (rx_in_valid) begin
                if (rx_in.last) begin
                    byte_cnt <= '0; // Next frame starts clean
                    bad_seen <= 1'b0;
                end else begin
                    byte_cnt <= cnt_next;
                    bad_seen <= bad_next;
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        beat_q <= rx_in;
        drop_q <= rx_in.last & (bad_next | oversize);
    end

    assign fifo_wr = '{wr: wr_q, beat: beat_q, drop: drop_q};

    // A MAC never sends an empty beat
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_in_valid |-> (rx_in.keep != '0));

endmodule

/* source/rx_output_stage.sv */
// Output stage with pipelined RAM read tracking and a valid/ready holding register
`timescale 1ns/100ps

module rx_output_stage
    import eth_fifo_pkg::*;
(
    input  logic     logic_clk,
    input  logic     logic_rst,
    input  rx_beat_t rd_beat,
    input  logic     rd_avail,
    output logic     rd_en,
    output rx_beat_t rx_out,
    output logic     rx_out_valid,
    input  logic     rx_out_ready
);

    logic     stage_valid; // RAM read data sitting on rd_beat
    logic     out_valid;
    rx_beat_t out_beat;
    logic     out_load;
    logic     stage_free;

    always_comb begin
        out_load   = stage_valid && (!out_valid || rx_out_ready);
        stage_free = !stage_valid || out_load;
        rd_en      = rd_avail && stage_free; // Never more than two beats held
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            stage_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            if (rd_en) begin
                stage_valid <= 1'b1;
            end else if (out_load) begin
                stage_valid <= 1'b0;
            end

            if (out_load) begin
                out_valid <= 1'b1;
            end else if (rx_out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (out_load) begin
            out_beat      <= rd_beat;
            out_beat.bad  <= 1'b0; // Bad frames never reach the output
        end
    end

    assign rx_out       = out_beat;
    assign rx_out_valid = out_valid;

    // Stalled beat stays put until it transfers
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_out_valid && !rx_out_ready) |=> (rx_out_valid && $stable(rx_out)));

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset generator
`timescale 1ns/100ps

module tb_clock_gen (
    output logic logic_clk,
    output logic logic_rst
);

    initial begin
        logic_clk = 1'b0;
        forever #10 logic_clk = ~logic_clk; // 20 ns period
    end

    initial begin
        logic_rst = 1'b1;
        repeat (16) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0; // Released away from the active edge
    end

endmodule

/* testbench/tb_eth_rx_fifo.sv */
// Directed tests, compare tasks, xorshift generator and reference beat queue for the RX FIFO
`timescale 1ns/100ps

module tb_eth_rx_fifo
    import eth_fifo_pkg::*;
();

    localparam int DEPTH        = 16;
    localparam int TIMEOUT      = 5000; // Cycles per wait
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    logic         logic_clk;
    logic         logic_rst;
    rx_beat_t     rx_in;
    logic         rx_in_valid;
    pkt_len_t     cfg_max_pkt_len;
    rx_beat_t     rx_out;
    logic         rx_out_valid;
    logic         rx_out_ready = 1'b1;
    fifo_status_t status;

    rx_beat_t    model[$]; // Beats still expected on rx_out
    logic [31:0] data_seed  = 32'd58;
    logic [31:0] ready_seed = 32'd58;
    int          ready_mode = READY_HIGH;

    int value_errors    = 0;
    int protocol_errors = 0;
    int timeout_errors  = 0;
    int ovf_count       = 0;
    int bad_count       = 0;
    int good_count      = 0;
    int beat_count      = 0;
    int exp_ovf         = 0;
    int exp_bad         = 0;
    int exp_good        = 0;

    logic     held_valid = 1'b0;
    rx_beat_t held_beat;

    tb_clock_gen i_clock_gen (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst)
    );

    eth_rx_fifo_top #(
        .FIFO_DEPTH (DEPTH)
    ) i_dut (
        .logic_clk       (logic_clk),
        .logic_rst       (logic_rst),
        .rx_in           (rx_in),
        .rx_in_valid     (rx_in_valid),
        .cfg_max_pkt_len (cfg_max_pkt_len),
        .rx_out          (rx_out),
        .rx_out_valid    (rx_out_valid),
        .rx_out_ready    (rx_out_ready),
        .status          (status)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_beat(input string name, input rx_beat_t got, input rx_beat_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_status(input string name, input fifo_status_t got,
                                input fifo_status_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: %s count got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Output ready pattern
    always @(negedge logic_clk) begin
        case (ready_mode)
            READY_LOW: rx_out_ready = 1'b0;
            READY_RANDOM: begin
                ready_seed   = xorshift(ready_seed);
                rx_out_ready = ready_seed[1:0] != 2'b00; // About 3 in 4 cycles
            end
            default: rx_out_ready = 1'b1;
        endcase
    end

    // Output and status monitor
    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            ovf_count  += status.overflow;
            bad_count  += status.bad_frame;
            good_count += status.good_frame;
            if (held_valid) begin
                if (!rx_out_valid) begin
                    $display("rx_out_valid fell before the stalled beat transferred");
                    protocol_errors++;
                end else begin
                    check_beat("rx_out held", rx_out, held_beat);
                end
            end
            if (rx_out_valid && rx_out_ready) begin
                beat_count++;
                if (model.size() == 0) begin
                    $display("A beat left rx_out while no beat was expected");
                    protocol_errors++;
                end else begin
                    check_beat("rx_out", rx_out, model.pop_front());
                end
            end
            held_valid = rx_out_valid && !rx_out_ready;
            held_beat  = rx_out;
        end
    end

    task automatic send_frame(input int nbytes, input int bad_beat, input bit survives);
        int       nbeats;
        int       left;
        rx_beat_t b;
        nbeats = (nbytes + 7) / 8;
        for (int i = 0; i < nbeats; i++) begin
            left         = nbytes - 8 * i;
            data_seed    = xorshift(data_seed);
            b.data[63:32] = data_seed;
            data_seed    = xorshift(data_seed);
            b.data[31:0] = data_seed;
            b.keep       = (left >= 8) ? 8'hff : 8'((1 << left) - 1); // Low bytes first
            b.last       = (i == nbeats - 1);
            b.bad        = (i == bad_beat);
            @(negedge logic_clk);
            rx_in       = b;
            rx_in_valid = 1'b1;
            if (survives) begin
                b.bad = 1'b0;
                model.push_back(b);
            end
        end
        @(negedge logic_clk);
        rx_in_valid = 1'b0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (logic_rst && cycles < 100) begin
            @(negedge logic_clk);
            cycles++;
        end
        if (logic_rst) begin
            $display("Reset was never released");
            timeout_errors++;
        end
    endtask

    // FIFO holds at most the beats still expected, so this keeps frames from overflowing
    task automatic wait_for_room(input int nbytes);
        int cycles;
        int nbeats;
        cycles = 0;
        nbeats = (nbytes + 7) / 8;
        while (model.size() + nbeats > DEPTH && cycles < TIMEOUT) begin
            @(negedge logic_clk);
            cycles++;
        end
        if (model.size() + nbeats > DEPTH) begin
            $display("Timed out waiting for FIFO room, %0d beats pending", model.size());
            timeout_errors++;
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (model.size() != 0 && cycles < TIMEOUT) begin
            @(negedge logic_clk);
            cycles++;
        end
        if (model.size() != 0) begin
            $display("Timed out with %0d expected beats never delivered", model.size());
            timeout_errors++;
        end
    endtask

    task automatic wait_for_status();
        int cycles;
        cycles = 0;
        while ((ovf_count < exp_ovf || bad_count < exp_bad || good_count < exp_good)
               && cycles < TIMEOUT) begin
            @(negedge logic_clk);
            cycles++;
        end
        if (ovf_count < exp_ovf || bad_count < exp_bad || good_count < exp_good) begin
            $display("Timed out waiting for status pulses");
            timeout_errors++;
        end
        repeat (4) @(negedge logic_clk); // Catch any extra pulse
        check_count("overflow", ovf_count, exp_ovf);
        check_count("bad_frame", bad_count, exp_bad);
        check_count("good_frame", good_count, exp_good);
    endtask

    task automatic idle_after_reset();
        repeat (20) begin
            @(negedge logic_clk);
            check_flag("rx_out_valid", rx_out_valid, 1'b0);
            check_status("status", status, '0);
        end
    endtask

    task automatic good_frames();
        int lengths[6] = '{60, 64, 65, 77, 100, 128};
        foreach (lengths[i]) begin
            wait_for_room(lengths[i]);
            send_frame(lengths[i], -1, 1'b1);
        end
        exp_good += 6;
        wait_for_drain();
        wait_for_status();
    endtask

    task automatic bad_frame_drop();
        wait_for_room(64);
        send_frame(64, -1, 1'b1);
        wait_for_room(72);
        send_frame(72, 3, 1'b0); // Bad flag mid frame
        wait_for_room(50);
        send_frame(50, -1, 1'b1);
        exp_good += 2;
        exp_bad  += 1;
        wait_for_drain();
        wait_for_status();
    endtask

    task automatic length_limit();
        @(negedge logic_clk);
        cfg_max_pkt_len = 16'd40;
        wait_for_room(48);
        send_frame(48, -1, 1'b0);
        wait_for_room(40);
        send_frame(40, -1, 1'b1);
        exp_bad  += 1;
        exp_good += 1;
        wait_for_drain();
        wait_for_status();
        cfg_max_pkt_len = pkt_len_t'(DEFAULT_MAX_PKT_LEN);
    endtask

    task automatic random_backpressure();
        int len;
        ready_mode = READY_RANDOM;
        for (int n = 0; n < 30; n++) begin
            data_seed = xorshift(data_seed);
            len       = 1 + int'(data_seed % 128);
            wait_for_room(len);
            send_frame(len, -1, 1'b1);
        end
        exp_good += 30;
        wait_for_drain();
        wait_for_status();
        ready_mode = READY_HIGH;
    endtask

    task automatic overflow_drop();
        int beats_before;
        ready_mode = READY_LOW;
        repeat (3) @(negedge logic_clk);
        beats_before = beat_count;
        for (int n = 0; n < 4; n++) begin
            send_frame(32, -1, 1'b1);
        end
        send_frame(32, -1, 1'b0); // Finds the FIFO full
        exp_good += 4;
        exp_ovf  += 1;
        wait_for_status();
        check_flag("rx_out_valid while stalled", rx_out_valid, 1'b1);
        check_beat("rx_out while stalled", rx_out, model[0]);
        ready_mode = READY_HIGH;
        wait_for_drain();
        repeat (8) @(negedge logic_clk); // A stray fifth frame would follow at once
        check_count("rx_out beats after stall", beat_count - beats_before, 16);
    endtask

    initial begin
        rx_in           = '0;
        rx_in_valid     = 1'b0;
        cfg_max_pkt_len = pkt_len_t'(DEFAULT_MAX_PKT_LEN);
        wait_reset_release();
        idle_after_reset();
        good_frames();
        bad_frame_drop();
        length_limit();
        random_backpressure();
        overflow_drop();
        repeat (10) @(negedge logic_clk);
        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
